//--- tb_vdp.sv
/*
 * Testbench for the bitmap display processor.
 * Models the two VRAM banks, loads palette and VRAM through the host port,
 * checks VRAM write pulses and raster readback, and feeds expected colours
 * to the checker module, which compares the VGA outputs.
 */

`timescale 1ns/100ps

module tb_vdp
    import vdp_pkg::*;
();

    logic clk = 1'b0;
    logic reset;
    logic [15:0] host_address;
    logic [15:0] host_write_data;
    logic host_write_en;
    logic host_read_en;
    logic [15:0] host_read_data;
    logic [13:0] vram_address_even;
    logic [13:0] vram_address_odd;
    logic vram_we_even;
    logic vram_we_odd;
    logic [15:0] vram_write_data_even;
    logic [15:0] vram_write_data_odd;
    logic [15:0] vram_read_data_even = '0;
    logic [15:0] vram_read_data_odd = '0;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;

    logic [15:0] vram_even [16384];
    logic [15:0] vram_odd [16384];
    logic [11:0] palette_shadow [256];

    int seed = 16;
    int write_errors = 0;
    int read_errors = 0;
    int total_errors;

    // Raster position tracked from frame_ended, for expected colours
    int frame_pos;
    logic pos_valid;
    logic check_enable;
    logic [11:0] expected_rgb;
    logic expected_active;
    logic expected_valid;

    always #5 clk = ~clk;

    vdp_top dut (.*);

    tb_vdp_checker output_checker (
        .clk(clk),
        .reset(reset),
        .check_enable(check_enable),
        .frame_ended(frame_ended),
        .line_ended(line_ended),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .active_display(active_display),
        .r(r),
        .g(g),
        .b(b),
        .expected_rgb(expected_rgb),
        .expected_active(expected_active),
        .expected_valid(expected_valid)
    );

    // Two synchronous VRAM banks
    always @(posedge clk) begin
        if (vram_we_even) begin
            vram_even[vram_address_even] <= vram_write_data_even;
        end
        if (vram_we_odd) begin
            vram_odd[vram_address_odd] <= vram_write_data_odd;
        end
        vram_read_data_even <= vram_even[vram_address_even];
        vram_read_data_odd <= vram_odd[vram_address_odd];
    end

    // Colour for one screen position: 2x/4x doubled 8 bpp bitmap
    function automatic logic [11:0] reference_color(input logic [11:0] x,
                                                    input logic [10:0] y);
        logic [13:0] word_address;
        logic [15:0] word;
        logic [7:0] index;
        word_address = {y[8:2], x[9:3]};
        word = x[1] ? vram_odd[word_address] : vram_even[word_address];
        index = x[2] ? word[15:8] : word[7:0];
        return palette_shadow[index];
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            frame_pos <= 0;
            pos_valid <= 1'b0;
        end else if (frame_ended) begin
            frame_pos <= 0;
            pos_valid <= 1'b1;
        end else begin
            frame_pos <= frame_pos + 1;
        end
    end

    // Expected output for the next cycle, four cycles behind the raster
    always @(posedge clk) begin : expected_gen
        int p;
        logic act;
        p = frame_pos - 3;
        act = (p % 800 < 640) && (p / 800 < 480);
        if (pos_valid && p >= 0) begin
            expected_active <= act;
            expected_rgb <= act ? reference_color(12'(p % 800), 11'(p / 800)) : 12'd0;
            expected_valid <= 1'b1;
        end else begin
            expected_valid <= 1'b0;
        end
    end

    function automatic logic raster_active_now();
        return pos_valid && (frame_pos % 800 < 640) && (frame_pos / 800 < 480);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic write_register(input logic [4:0] number, input logic [15:0] data);
        @(negedge clk);
        host_address = {11'd0, number};
        host_write_data = data;
        host_write_en = 1'b1;
        @(negedge clk);
        host_write_en = 1'b0;
    endtask

    task automatic wait_frame_end();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 2 * 800 * 524) begin
                abort_run("Timeout: no frame_ended pulse seen");
            end
        end while (!frame_ended);
    endtask

    // Waits for one VRAM write pulse and checks bank, address, data and slot
    task automatic check_vram_write(input logic [14:0] full_address, input logic [15:0] data);
        int cycles;
        logic bank;
        logic [13:0] address;
        bank = full_address[0];
        address = full_address[14:1];
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 2 * 800 * 524) begin
                abort_run("Timeout: staged VRAM write was never performed");
            end
        end while (!vram_we_even && !vram_we_odd);
        if (raster_active_now()) begin
            $display("VRAM write pulse occurred during active display at %0t", $time);
            write_errors++;
        end
        if (vram_we_odd !== bank || vram_we_even !== !bank) begin
            $display("ERROR t=%0t vram_we_odd expected %b actual %b", $time, bank, vram_we_odd);
            write_errors++;
        end
        if ((bank ? vram_address_odd : vram_address_even) !== address) begin
            $display("ERROR t=%0t vram_address expected %h actual %h", $time, address,
                     bank ? vram_address_odd : vram_address_even);
            write_errors++;
        end
        if ((bank ? vram_write_data_odd : vram_write_data_even) !== data) begin
            $display("ERROR t=%0t vram_write_data expected %h actual %h", $time, data,
                     bank ? vram_write_data_odd : vram_write_data_even);
            write_errors++;
        end
        @(posedge clk);
        if (vram_we_even || vram_we_odd) begin
            $display("VRAM write pulse lasted longer than one cycle at %0t", $time);
            write_errors++;
        end
    endtask

    initial begin
        logic [14:0] full_address;
        logic [15:0] data;
        logic [15:0] expected_x;
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        check_enable = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            vram_even[i] = 16'($random(seed));
            vram_odd[i] = 16'($random(seed));
        end
        for (int i = 0; i < 256; i++) begin
            palette_shadow[i] = 12'($random(seed));
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Palette loaded from index 0 with auto increment
        write_register(REG_PALETTE_ADDR, 16'd0);
        for (int i = 0; i < 256; i++) begin
            write_register(REG_PALETTE_DATA, {4'd0, palette_shadow[i]});
        end

        wait_frame_end();
        full_address = 15'($random(seed));
        write_register(REG_VRAM_ADDR, {1'b0, full_address});
        write_register(REG_VRAM_INC, 16'd5);
        for (int i = 0; i < 6; i++) begin
            data = 16'($random(seed));
            write_register(REG_VRAM_DATA, data);
            check_vram_write(full_address, data);
            full_address = full_address + 15'd5;
        end
        $display("Test VRAM writes: %s", write_errors == 0 ? "pass" : "fail");

        // Raster readback at the start of the first active line
        wait_frame_end();
        @(negedge clk);
        host_address = 16'd2;
        host_read_en = 1'b1;
        @(negedge clk);
        host_read_en = 1'b0;
        if (host_read_data !== 16'd0) begin
            $display("ERROR t=%0t host_read_data expected %h actual %h", $time, 16'd0,
                     host_read_data);
            read_errors++;
        end
        host_address = 16'd0;
        host_read_en = 1'b1;
        expected_x = 16'(frame_pos % 800);
        @(negedge clk);
        host_read_en = 1'b0;
        if (host_read_data !== expected_x) begin
            $display("ERROR t=%0t host_read_data expected %h actual %h", $time, expected_x,
                     host_read_data);
            read_errors++;
        end
        $display("Test raster readback: %s", read_errors == 0 ? "pass" : "fail");

        // Two whole frames, starting at the first pixel of a frame
        wait_frame_end();
        @(negedge clk);
        check_enable = 1'b1;
        repeat (2) wait_frame_end();
        @(negedge clk);
        check_enable = 1'b0;
        if (output_checker.pixels_checked != 2 * 640 * 480) begin
            $display("Pixel check covered %0d active pixels instead of two frames",
                     output_checker.pixels_checked);
            read_errors++;
        end
        $display("Test timing: %s", output_checker.timing_errors == 0 ? "pass" : "fail");
        $display("Test pixel path: %s", output_checker.pixel_errors == 0 ? "pass" : "fail");
        $display("Test palette writes: %s",
                 output_checker.pixel_errors == 0 ? "pass" : "fail");

        total_errors = write_errors + read_errors + output_checker.timing_errors
                       + output_checker.pixel_errors;
        $display("Summary: %0d pixels checked, %0d errors", output_checker.pixels_checked,
                 total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_vdp_checker.sv
/*
 * Checker for the display processor testbench.
 * Counts frame, line, active and sync cycles from the DUT strobes and
 * compares the VGA colour against the expected colour from the testbench.
 */

`timescale 1ns/100ps

module tb_vdp_checker (
    input  logic clk,
    input  logic reset,
    input  logic check_enable,
    input  logic frame_ended,
    input  logic line_ended,
    input  logic vga_hsync,
    input  logic vga_vsync,
    input  logic active_display,
    input  logic [3:0] r,
    input  logic [3:0] g,
    input  logic [3:0] b,
    input  logic [11:0] expected_rgb,
    input  logic expected_active,
    input  logic expected_valid
);

    int timing_errors = 0;
    int pixel_errors = 0;
    int pixels_checked = 0;

    int frame_cycles;
    int line_active;
    int line_hsync_low;
    int frame_vsync_low;
    int frame_active_lines;
    logic line_seen;
    logic frame_seen;

    always @(posedge clk) begin : timing_check
        int active_count;
        int hsync_count;
        int vsync_count;
        int lines_count;
        active_count = line_active + (active_display ? 1 : 0);
        hsync_count = line_hsync_low + (vga_hsync ? 0 : 1);
        vsync_count = frame_vsync_low + (vga_vsync ? 0 : 1);
        lines_count = frame_active_lines + (active_count > 0 ? 1 : 0);
        if (reset || !check_enable) begin
            frame_cycles <= 0;
            line_active <= 0;
            line_hsync_low <= 0;
            frame_vsync_low <= 0;
            frame_active_lines <= 0;
            line_seen <= 1'b0;
            frame_seen <= 1'b0;
        end else begin
            frame_cycles <= frame_cycles + 1;
            line_active <= active_count;
            line_hsync_low <= hsync_count;
            frame_vsync_low <= vsync_count;
            if (line_ended) begin
                if (line_seen && active_count != 0 && active_count != 640) begin
                    $display("ERROR t=%0t active_display cycles expected %0d actual %0d",
                             $time, 640, active_count);
                    timing_errors++;
                end
                if (line_seen && hsync_count != 96) begin
                    $display("ERROR t=%0t vga_hsync low cycles expected %0d actual %0d",
                             $time, 96, hsync_count);
                    timing_errors++;
                end
                line_active <= 0;
                line_hsync_low <= 0;
                line_seen <= 1'b1;
                frame_active_lines <= lines_count;
            end
            if (frame_ended) begin
                if (frame_seen && frame_cycles + 1 != 800 * 524) begin
                    $display("ERROR t=%0t frame_ended period expected %0d actual %0d",
                             $time, 800 * 524, frame_cycles + 1);
                    timing_errors++;
                end
                if (frame_seen && lines_count != 480) begin
                    $display("ERROR t=%0t active lines expected %0d actual %0d",
                             $time, 480, lines_count);
                    timing_errors++;
                end
                // Two full lines of vertical sync per frame
                if (frame_seen && vsync_count != 2 * 800) begin
                    $display("ERROR t=%0t vga_vsync low cycles expected %0d actual %0d",
                             $time, 2 * 800, vsync_count);
                    timing_errors++;
                end
                frame_cycles <= 0;
                frame_active_lines <= 0;
                frame_vsync_low <= 0;
                frame_seen <= 1'b1;
            end
        end
    end

    // Colour must match inside the active area and be black outside
    always @(posedge clk) begin
        if (!reset && check_enable && expected_valid) begin
            if (active_display !== expected_active) begin
                $display("ERROR t=%0t active_display expected %b actual %b", $time,
                         expected_active, active_display);
                pixel_errors++;
            end
            if ({r, g, b} !== expected_rgb) begin
                $display("ERROR t=%0t rgb expected %h actual %h", $time, expected_rgb,
                         {r, g, b});
                pixel_errors++;
            end
            if (expected_active) begin
                pixels_checked++;
            end
        end
    end

endmodule

//--- vdp_bitmap_fetch.sv
/*
 * VRAM bus driver for the 8 bpp bitmap layer.
 * During active display both banks are read at the raster position and
 * one byte is picked per pixel. In blanking the staged host write is
 * performed on the selected bank and acknowledged with vram_written.
 */

`timescale 1ns/100ps

module vdp_bitmap_fetch
    import vdp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  raster_t raster,
    input  vram_write_t vram_write,
    input  logic [15:0] vram_read_data_even,
    input  logic [15:0] vram_read_data_odd,
    output logic [13:0] vram_address_even,
    output logic [13:0] vram_address_odd,
    output logic vram_we_even,
    output logic vram_we_odd,
    output logic [15:0] vram_write_data_even,
    output logic [15:0] vram_write_data_odd,
    output logic vram_written,
    output logic [7:0] pixel_index
);

    logic [13:0] fetch_address;
    logic write_slot;

    // Bit 0 is the bank, bit 1 the byte within the word
    logic [1:0] select_d1;
    logic [1:0] select_d2;

    logic [15:0] read_data_even_r;
    logic [15:0] read_data_odd_r;
    logic [15:0] selected_word;

    // 2x horizontal and 4x vertical pixel doubling
    assign fetch_address = {raster.y[8:2], raster.x[9:3]};

    assign write_slot = !raster.active && vram_write.pending;
    assign vram_written = write_slot;

    always_comb begin
        vram_we_even = 1'b0;
        vram_we_odd = 1'b0;
        if (raster.active) begin
            vram_address_even = fetch_address;
            vram_address_odd = fetch_address;
        end else begin
            vram_address_even = vram_write.address;
            vram_address_odd = vram_write.address;
            vram_we_even = write_slot && !vram_write.bank;
            vram_we_odd = write_slot && vram_write.bank;
        end
    end

    assign vram_write_data_even = vram_write.data;
    assign vram_write_data_odd = vram_write.data;

    // Select bits follow the read through the VRAM and the word register
    always_ff @(posedge clk) begin
        if (reset) begin
            select_d1 <= '0;
            select_d2 <= '0;
        end else begin
            select_d1 <= {raster.x[2], raster.x[1]};
            select_d2 <= select_d1;
        end
    end

    always_ff @(posedge clk) begin
        read_data_even_r <= vram_read_data_even;
        read_data_odd_r <= vram_read_data_odd;
    end

    always_comb begin
        selected_word = select_d2[0] ? read_data_odd_r : read_data_even_r;
        pixel_index = select_d2[1] ? selected_word[15:8] : selected_word[7:0];
    end

endmodule

//--- vdp_color_out.sv
/*
 * Colour output stage for the VGA port.
 * Delays the raster active and sync levels to line up with the palette
 * colour, blanks outside the active area and registers all outputs.
 */

`timescale 1ns/100ps

module vdp_color_out
    import vdp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  raster_t raster,
    input  rgb_t color,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic active_display
);

    typedef struct packed {
        logic active;
        logic hsync;
        logic vsync;
    } video_level_t;

    localparam int DELAY_STAGES = PIXEL_LATENCY - 1;
    localparam video_level_t LEVEL_IDLE = '{active: 1'b0, hsync: 1'b1, vsync: 1'b1};

    video_level_t level_delay [DELAY_STAGES];
    video_level_t level_aligned;

    assign level_aligned = level_delay[DELAY_STAGES - 1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DELAY_STAGES; i++) begin
                level_delay[i] <= LEVEL_IDLE;
            end
        end else begin
            level_delay[0] <= '{active: raster.active, hsync: raster.hsync,
                                vsync: raster.vsync};
            for (int i = 1; i < DELAY_STAGES; i++) begin
                level_delay[i] <= level_delay[i - 1];
            end
        end
    end

    // Final register stage, black outside the active area
    always_ff @(posedge clk) begin
        if (reset) begin
            r <= '0;
            g <= '0;
            b <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            active_display <= 1'b0;
        end else begin
            r <= level_aligned.active ? color.r : 4'd0;
            g <= level_aligned.active ? color.g : 4'd0;
            b <= level_aligned.active ? color.b : 4'd0;
            vga_hsync <= level_aligned.hsync;
            vga_vsync <= level_aligned.vsync;
            active_display <= level_aligned.active;
        end
    end

endmodule

//--- vdp_host_regs.sv
/*
 * Host register port of the display processor.
 * Decodes writes to the palette and VRAM registers, sequences palette
 * entry writes, stages VRAM writes until the fetch unit performs them,
 * and returns the raster position on reads.
 */

`timescale 1ns/100ps

module vdp_host_regs
    import vdp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic [15:0] host_address,
    input  logic [15:0] host_write_data,
    input  logic host_write_en,
    input  logic host_read_en,
    input  raster_t raster,
    input  logic vram_written,
    output logic [15:0] host_read_data,
    output palette_write_t pal_write,
    output vram_write_t vram_write
);

    logic [4:0] reg_number;
    logic palette_data_write;
    logic vram_data_write;

    logic [7:0] palette_address;
    logic [14:0] vram_address_full;
    logic [7:0] vram_increment;
    logic [15:0] vram_data;
    logic vram_pending;

    assign reg_number = host_address[4:0];
    assign palette_data_write = host_write_en && (reg_number == REG_PALETTE_DATA);
    assign vram_data_write = host_write_en && (reg_number == REG_VRAM_DATA);

    // Palette entry goes out in the same cycle as the data write
    always_comb begin
        pal_write.en = palette_data_write;
        pal_write.address = palette_address;
        pal_write.color = rgb_t'(host_write_data[11:0]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            palette_address <= '0;
            vram_address_full <= '0;
            vram_increment <= '0;
            vram_pending <= 1'b0;
        end else begin
            if (palette_data_write) begin
                palette_address <= palette_address + 8'd1;
            end

            // Completed write advances the address by the increment
            if (vram_pending && vram_written) begin
                vram_pending <= 1'b0;
                vram_address_full <= vram_address_full + {7'd0, vram_increment};
            end

            if (host_write_en) begin
                case (reg_number)
                    REG_PALETTE_ADDR: palette_address <= host_write_data[7:0];
                    REG_VRAM_ADDR: vram_address_full <= host_write_data[14:0];
                    REG_VRAM_DATA: vram_pending <= 1'b1;
                    REG_VRAM_INC: vram_increment <= host_write_data[7:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vram_data_write) begin
            vram_data <= host_write_data;
        end
    end

    // Bit 0 of the full address picks the odd bank
    always_comb begin
        vram_write.pending = vram_pending;
        vram_write.address = vram_address_full[14:1];
        vram_write.data = vram_data;
        vram_write.bank = vram_address_full[0];
    end

    // Readback of x or y position, valid the cycle after the request
    always_ff @(posedge clk) begin
        if (host_read_en) begin
            if (host_address[1]) begin
                host_read_data <= {5'd0, raster.y};
            end else begin
                host_read_data <= {4'd0, raster.x};
            end
        end
    end

endmodule

//--- vdp_lite.f
vdp_pkg.sv
vdp_raster_timing.sv
vdp_host_regs.sv
vdp_bitmap_fetch.sv
vdp_palette.sv
vdp_color_out.sv
vdp_top.sv
tb_vdp_checker.sv
tb_vdp.sv

//--- vdp_palette.sv
/*
 * 256-entry palette RAM mapping 8-bit pixels to 12-bit RGB.
 * One write port from the host registers, one registered read port
 * indexed by the bitmap pixel. Read latency is one cycle.
 */

`timescale 1ns/100ps

module vdp_palette
    import vdp_pkg::*;
(
    input  logic clk,
    input  palette_write_t pal_write,
    input  logic [7:0] pixel_index,
    output rgb_t color
);

    rgb_t palette_ram [256];

    always_ff @(posedge clk) begin
        if (pal_write.en) begin
            palette_ram[pal_write.address] <= pal_write.color;
        end
    end

    // Registered read, feeds the colour output stage
    always_ff @(posedge clk) begin
        color <= palette_ram[pixel_index];
    end

endmodule

//--- vdp_pkg.sv
/*
 * Shared definitions for the VGA display processor.
 * Holds the 640x480 timing constants, the host register map and the
 * packed structs passed between blocks. Import with a wildcard in each module.
 */

package vdp_pkg;

    // 640x480 at 60 Hz
    localparam int H_ACTIVE = 640;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACKPORCH = 48;
    localparam int H_TOTAL = H_ACTIVE + H_FRONTPORCH + H_SYNC + H_BACKPORCH;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONTPORCH = 11;
    localparam int V_SYNC = 2;
    localparam int V_BACKPORCH = 31;
    localparam int V_TOTAL = V_ACTIVE + V_FRONTPORCH + V_SYNC + V_BACKPORCH;

    // First counter value inside each sync pulse
    localparam int H_SYNC_START = H_ACTIVE + H_FRONTPORCH;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONTPORCH;

    // Host register numbers, decoded from the low address bits
    localparam logic [4:0] REG_PALETTE_ADDR = 5'd2;
    localparam logic [4:0] REG_PALETTE_DATA = 5'd3;
    localparam logic [4:0] REG_VRAM_ADDR = 5'd4;
    localparam logic [4:0] REG_VRAM_DATA = 5'd5;
    localparam logic [4:0] REG_VRAM_INC = 5'd6;

    // Raster position to registered colour output
    localparam int PIXEL_LATENCY = 4;

    // Current raster position with undelayed active and sync levels
    typedef struct packed {
        logic [11:0] x;
        logic [10:0] y;
        logic active;
        logic hsync;
        logic vsync;
    } raster_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // One palette entry write, valid while en is high
    typedef struct packed {
        logic en;
        logic [7:0] address;
        rgb_t color;
    } palette_write_t;

    // Staged VRAM write, held until the fetch unit performs it
    typedef struct packed {
        logic pending;
        logic [13:0] address;
        logic [15:0] data;
        logic bank;
    } vram_write_t;

endpackage

//--- vdp_raster_timing.sv
/*
 * Raster counters for the 640x480 VGA mode.
 * Produces the current x and y position with active and sync levels,
 * plus single-cycle end of line and end of frame strobes.
 */

`timescale 1ns/100ps

module vdp_raster_timing
    import vdp_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output raster_t raster,
    output logic line_ended,
    output logic frame_ended
);

    logic [11:0] x;
    logic [10:0] y;
    logic x_last;
    logic y_last;

    assign x_last = (x == 12'(H_TOTAL - 1));
    assign y_last = (y == 11'(V_TOTAL - 1));

    // Horizontal counter wraps every line, vertical counter every frame
    always_ff @(posedge clk) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else begin
            if (x_last) begin
                x <= '0;
                if (y_last) begin
                    y <= '0;
                end else begin
                    y <= y + 11'd1;
                end
            end else begin
                x <= x + 12'd1;
            end
        end
    end

    assign line_ended = x_last;
    assign frame_ended = x_last && y_last;

    always_comb begin
        raster.x = x;
        raster.y = y;
        raster.active = (x < 12'(H_ACTIVE)) && (y < 11'(V_ACTIVE));

        // Both syncs are active low inside their windows
        raster.hsync = !((x >= 12'(H_SYNC_START)) && (x < 12'(H_SYNC_START + H_SYNC)));
        raster.vsync = !((y >= 11'(V_SYNC_START)) && (y < 11'(V_SYNC_START + V_SYNC)));
    end

endmodule

//--- vdp_top.sv
/*
 * Top level of the bitmap display processor.
 * Connects raster timing, host registers, VRAM fetch, palette and colour
 * output to the host port, the two VRAM banks and the VGA pins.
 */

`timescale 1ns/100ps

module vdp_top
    import vdp_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Host port
    input  logic [15:0] host_address,
    input  logic [15:0] host_write_data,
    input  logic host_write_en,
    input  logic host_read_en,
    output logic [15:0] host_read_data,

    // VRAM banks
    output logic [13:0] vram_address_even,
    output logic vram_we_even,
    output logic [15:0] vram_write_data_even,
    input  logic [15:0] vram_read_data_even,
    output logic [13:0] vram_address_odd,
    output logic vram_we_odd,
    output logic [15:0] vram_write_data_odd,
    input  logic [15:0] vram_read_data_odd,

    // VGA output
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic active_display,

    // Undelayed strobes
    output logic line_ended,
    output logic frame_ended
);

    raster_t raster;
    palette_write_t pal_write;
    vram_write_t vram_write;
    logic vram_written;
    logic [7:0] pixel_index;
    rgb_t color;

    vdp_raster_timing raster_timing (
        .clk(clk),
        .reset(reset),
        .raster(raster),
        .line_ended(line_ended),
        .frame_ended(frame_ended)
    );

    vdp_host_regs host_regs (
        .clk(clk),
        .reset(reset),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .raster(raster),
        .vram_written(vram_written),
        .host_read_data(host_read_data),
        .pal_write(pal_write),
        .vram_write(vram_write)
    );

    vdp_bitmap_fetch bitmap_fetch (
        .clk(clk),
        .reset(reset),
        .raster(raster),
        .vram_write(vram_write),
        .vram_read_data_even(vram_read_data_even),
        .vram_read_data_odd(vram_read_data_odd),
        .vram_address_even(vram_address_even),
        .vram_address_odd(vram_address_odd),
        .vram_we_even(vram_we_even),
        .vram_we_odd(vram_we_odd),
        .vram_write_data_even(vram_write_data_even),
        .vram_write_data_odd(vram_write_data_odd),
        .vram_written(vram_written),
        .pixel_index(pixel_index)
    );

    vdp_palette palette (
        .clk(clk),
        .pal_write(pal_write),
        .pixel_index(pixel_index),
        .color(color)
    );

    vdp_color_out color_out (
        .clk(clk),
        .reset(reset),
        .raster(raster),
        .color(color),
        .r(r),
        .g(g),
        .b(b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .active_display(active_display)
    );

endmodule
